/* eval_pkg.sv */
`default_nettype none

package eval_pkg;

   // Score word width used by the pair struct and the top-level default
   localparam int EVAL_WIDTH_DEFAULT = 24;

   // Phase clamp and blend divisor
   localparam int PHASE_MAX = 62;

   // Divide by 62 done as a multiply by a scaled reciprocal
   localparam int RECIP_SHIFT = 20;
   localparam int RECIP_62 = (1 << RECIP_SHIFT) / PHASE_MAX; // 16912

   localparam logic [2:0] KIND_EMPTY = 3'd0;
   localparam logic [2:0] KIND_UNUSED = 3'd7; // Decoded as empty

   // One square code; kind 1..6 is pawn, knight, bishop, rook, queen, king
   typedef struct packed
   {
      logic       black;                      // Set for a black piece
      logic [2:0] kind;
   } piece_t;

   // Square 0 (a1) sits in the low nibble
   typedef piece_t [63:0] board_t;

   // Clamped piece count, 0 to PHASE_MAX
   typedef logic [5:0] phase_t;

   // Middlegame and endgame totals from the material evaluator
   typedef struct packed
   {
      logic signed [EVAL_WIDTH_DEFAULT-1:0] mg;
      logic signed [EVAL_WIDTH_DEFAULT-1:0] eg;
   } score_pair_t;

   // Piece values by kind, index 0 is an empty square
   localparam logic [15:0] PIECE_MG [0:6] = '{
      16'd0,                                  // Empty
      16'd100,                                // Pawn
      16'd320,                                // Knight
      16'd330,                                // Bishop
      16'd500,                                // Rook
      16'd950,                                // Queen
      16'd0                                   // King
   };

   localparam logic [15:0] PIECE_EG [0:6] = '{
      16'd0,
      16'd120,
      16'd300,
      16'd320,
      16'd550,
      16'd1000,
      16'd0
   };

   // Kind with the unused code folded onto empty
   function automatic logic [2:0] piece_kind(input piece_t p);
      return (p.kind == KIND_UNUSED) ? KIND_EMPTY : p.kind;
   endfunction

endpackage

`default_nettype wire

/* board_phase.sv */
`default_nettype none

module board_phase
   import eval_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire board_t board,
   output phase_t      phase
);

   logic [63:0] occupied;                     // One bit per non-empty square
   logic [6:0]  count_d;                      // Up to 64 pieces
   logic [6:0]  count_q;

   for (genvar s = 0; s < 64; s++)
   begin : g_occ
      assign occupied[s] = (piece_kind(board[s]) != KIND_EMPTY);
   end

   // Population count of the occupancy mask
   always_comb
   begin
      count_d = '0;
      for (int s = 0; s < 64; s++)
      begin
         count_d = count_d + 7'(occupied[s]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count_q <= '0;
         phase <= '0;
      end
      else
      begin
         count_q <= count_d;                  // Count stage
         if (count_q > 7'(PHASE_MAX))         // Full boards clamp to 62
            phase <= phase_t'(PHASE_MAX);
         else
            phase <= count_q[5:0];
      end
   end

endmodule

`default_nettype wire

/* material_eval.sv */
`default_nettype none

module material_eval
   import eval_pkg::*;
#(
   parameter int EVAL_WIDTH = EVAL_WIDTH_DEFAULT
)
(
   input  wire logic    clk,
   input  wire logic    reset,
   input  wire logic    start,
   input  wire logic    clear_eval,
   input  wire board_t  board,
   output score_pair_t  score,
   output logic signed [31:0] material,
   output logic         material_valid
);

   // Signed value of each square, white positive
   logic signed [EVAL_WIDTH-1:0] sq_mg [64];
   logic signed [EVAL_WIDTH-1:0] sq_eg [64];

   // Rank partials
   logic signed [EVAL_WIDTH-1:0] rank_mg_d [8];
   logic signed [EVAL_WIDTH-1:0] rank_eg_d [8];
   logic signed [EVAL_WIDTH-1:0] rank_mg_q [8];
   logic signed [EVAL_WIDTH-1:0] rank_eg_q [8];

   logic signed [EVAL_WIDTH-1:0] mg_total;
   logic signed [EVAL_WIDTH-1:0] eg_total;
   logic                         start_q;     // Start aligned to partial stage

   for (genvar s = 0; s < 64; s++)
   begin : g_square
      logic [2:0]                   kind;
      logic signed [EVAL_WIDTH-1:0] mg_mag;
      logic signed [EVAL_WIDTH-1:0] eg_mag;

      assign kind = piece_kind(board[s]);
      assign mg_mag = EVAL_WIDTH'(PIECE_MG[kind]);
      assign eg_mag = EVAL_WIDTH'(PIECE_EG[kind]);
      assign sq_mg[s] = board[s].black ? -mg_mag : mg_mag; // Black counts against
      assign sq_eg[s] = board[s].black ? -eg_mag : eg_mag;
   end

   // Eight squares per rank
   always_comb
   begin
      for (int r = 0; r < 8; r++)
      begin
         rank_mg_d[r] = '0;
         rank_eg_d[r] = '0;
         for (int f = 0; f < 8; f++)
         begin
            rank_mg_d[r] = rank_mg_d[r] + sq_mg[r * 8 + f];
            rank_eg_d[r] = rank_eg_d[r] + sq_eg[r * 8 + f];
         end
      end
   end

   always_comb
   begin
      mg_total = '0;
      eg_total = '0;
      for (int r = 0; r < 8; r++)
      begin
         mg_total = mg_total + rank_mg_q[r];
         eg_total = eg_total + rank_eg_q[r];
      end
   end

   // Stage 1 partials, stage 2 totals
   always_ff @(posedge clk)
   begin
      rank_mg_q <= rank_mg_d;
      rank_eg_q <= rank_eg_d;
      score.mg <= mg_total;
      score.eg <= eg_total;
      material <= 32'(mg_total);              // Sign extended
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_q <= 1'b0;
         material_valid <= 1'b0;
      end
      else
      begin
         start_q <= start;
         if (start_q)
            material_valid <= 1'b1;           // Totals land this edge
         else if (clear_eval)
            material_valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* eval_sequencer.sv */
`default_nettype none

module eval_sequencer #(
   parameter int BLEND_LATENCY = 4
)
(
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic board_valid,
   input  wire logic material_valid,
   input  wire logic clear_eval,
   output logic      load_board,
   output logic      start,
   output logic      eval_valid
);

   localparam int CNT_W = $clog2(BLEND_LATENCY + 1);
   localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(BLEND_LATENCY - 1);

   typedef enum logic [1:0]
   {
      IDLE,
      WAIT_MATERIAL,
      WAIT_LATENCY,
      WAIT_CLEAR
   } state_t;

   state_t           state;
   logic             board_valid_q;           // Previous board_valid
   logic             board_rise;
   logic [CNT_W-1:0] lat_cnt;                 // Cycles spent in the blend pipe

   assign board_rise = board_valid && !board_valid_q;

   // Board register enable, only a fresh rise in IDLE takes a board
   assign load_board = (state == IDLE) && board_rise;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
         board_valid_q <= 1'b0;               // Level held through reset reads as a rise
         start <= 1'b0;
         eval_valid <= 1'b0;
         lat_cnt <= '0;
      end
      else
      begin
         board_valid_q <= board_valid;
         start <= load_board;                 // One cycle pulse

         case (state)
            IDLE:
            begin
               lat_cnt <= '0;
               if (load_board)
                  state <= WAIT_MATERIAL;
            end
            WAIT_MATERIAL:
            begin
               if (material_valid)
                  state <= WAIT_LATENCY;
            end
            WAIT_LATENCY:
            begin
               lat_cnt <= lat_cnt + 1'b1;
               if (lat_cnt == LAST_COUNT)     // Blend output settled
               begin
                  eval_valid <= 1'b1;
                  state <= WAIT_CLEAR;
               end
            end
            WAIT_CLEAR:
            begin
               if (clear_eval)                // Result retired
               begin
                  eval_valid <= 1'b0;
                  state <= IDLE;
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* taper_blend.sv */
`default_nettype none

module taper_blend
   import eval_pkg::*;
#(
   parameter int EVAL_WIDTH = EVAL_WIDTH_DEFAULT
)
(
   input  wire logic         clk,
   input  wire score_pair_t  score,
   input  wire phase_t       phase,
   output logic signed [EVAL_WIDTH-1:0] eval
);

   localparam int PROD_W = EVAL_WIDTH + 7;    // Score times a 7-bit weight
   localparam int SUM_W = PROD_W + 1;
   localparam int SCALE_W = SUM_W + 17;       // Times the 17-bit reciprocal

   localparam logic signed [16:0] RECIP = 17'(RECIP_62);

   // Added to negative values so the shift truncates toward zero
   localparam logic signed [SCALE_W-1:0] ROUND_BIAS = SCALE_W'((1 << RECIP_SHIFT) - 1);

   logic [6:0]                 mg_weight;
   logic [6:0]                 eg_weight;
   logic signed [PROD_W-1:0]   mg_prod;
   logic signed [PROD_W-1:0]   eg_prod;
   logic signed [SUM_W-1:0]    blend_sum;
   logic signed [SCALE_W-1:0]  scaled;
   logic signed [SCALE_W-1:0]  biased;

   // Full board weighs middlegame, empty board endgame
   assign mg_weight = {1'b0, phase};
   assign eg_weight = 7'(PHASE_MAX) - mg_weight;

   assign biased = scaled + (scaled[SCALE_W-1] ? ROUND_BIAS : '0);

   always_ff @(posedge clk)
   begin
      mg_prod <= score.mg * $signed(mg_weight);        // Stage 1
      eg_prod <= score.eg * $signed(eg_weight);
      blend_sum <= mg_prod + eg_prod;                  // Stage 2
      scaled <= blend_sum * RECIP;                     // Stage 3
      eval <= biased[RECIP_SHIFT +: EVAL_WIDTH];       // Stage 4 divide by 2^20
   end

endmodule

`default_nettype wire

/* position_eval.sv */
`default_nettype none

module position_eval
   import eval_pkg::*;
#(
   parameter int EVAL_WIDTH = EVAL_WIDTH_DEFAULT,
   parameter int BLEND_LATENCY = 4            // Stage count of taper_blend
)
(
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   board_valid,
   input  wire board_t board_in,
   input  wire logic   clear_eval,
   output logic signed [EVAL_WIDTH-1:0] eval,
   output logic        eval_valid,
   output logic signed [31:0] material
);

   board_t      board;                        // Held for the whole evaluation
   logic        load_board;
   logic        start;
   logic        material_valid;
   phase_t      phase;
   score_pair_t score;

   always_ff @(posedge clk)
   begin
      if (load_board)
         board <= board_in;
   end

   eval_sequencer #(
      .BLEND_LATENCY (BLEND_LATENCY)
   ) u_sequencer (
      .clk            (clk),
      .reset          (reset),
      .board_valid    (board_valid),
      .material_valid (material_valid),
      .clear_eval     (clear_eval),
      .load_board     (load_board),
      .start          (start),
      .eval_valid     (eval_valid)
   );

   board_phase u_phase (
      .clk   (clk),
      .reset (reset),
      .board (board),
      .phase (phase)
   );

   material_eval #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_material (
      .clk            (clk),
      .reset          (reset),
      .start          (start),
      .clear_eval     (clear_eval),
      .board          (board),
      .score          (score),
      .material       (material),
      .material_valid (material_valid)
   );

   taper_blend #(
      .EVAL_WIDTH (EVAL_WIDTH)
   ) u_blend (
      .clk   (clk),
      .score (score),
      .phase (phase),
      .eval  (eval)
   );

endmodule

`default_nettype wire

/* tb_position_eval.sv */
`default_nettype none

module tb_position_eval
   import eval_pkg::*;
();

   localparam int     NUM_BOARDS = 200;
   localparam int     NUM_IGNORE = 10;         // Boards with a rise during the hold
   localparam int     TIMEOUT = 100;           // Cycles per wait
   localparam int     EXP_LATENCY = 7;         // E0 to eval_valid
   localparam int     MAX_PHASE = 62;
   localparam longint RECIP = 16912;           // 2^20 / 62, integer part
   localparam longint SCALE = 64'd1 << 20;

   logic                                 clk;
   logic                                 reset;
   logic                                 board_valid;
   board_t                               board_in;
   logic                                 clear_eval;
   logic signed [EVAL_WIDTH_DEFAULT-1:0] eval;
   logic                                 eval_valid;
   logic signed [31:0]                   material;

   int checks;
   int errors;
   int test_err;                               // Error count when a test began

   position_eval #(
      .EVAL_WIDTH    (EVAL_WIDTH_DEFAULT),
      .BLEND_LATENCY (4)
   ) UUT (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid),
      .material    (material)
   );

   always #4 clk = ~clk;                       // Period 8

   function automatic piece_t random_piece();
      piece_t p;
      p.black = 1'($urandom_range(0, 1));
      p.kind = 3'($urandom_range(1, 6));       // Pawn to king
      return p;
   endfunction

   // Codes 0, 7, 8 and 15 all decode as empty
   function automatic piece_t random_empty();
      piece_t p;
      p.black = 1'($urandom_range(0, 1));
      p.kind = ($urandom_range(0, 1) == 1) ? 3'd7 : 3'd0;
      return p;
   endfunction

   function automatic board_t random_board(input bit dense);
      board_t b;
      int     holes;
      for (int s = 0; s < 64; s++)
      begin
         if (dense || $urandom_range(0, 1) == 1)
            b[s] = random_piece();
         else
            b[s] = random_empty();
      end
      if (dense)
      begin
         holes = int'($urandom_range(0, 2));   // 62 to 64 pieces
         for (int h = 0; h < holes; h++)
            b[$urandom_range(0, 63)] = random_empty();
      end
      return b;
   endfunction

   function automatic bit is_piece(input piece_t p);
      return (p.kind != 3'd0) && (p.kind != 3'd7);
   endfunction

   // White minus black over one value table
   function automatic int table_sum(input board_t b, input bit endgame);
      int sum;
      int v;
      sum = 0;
      for (int s = 0; s < 64; s++)
      begin
         if (is_piece(b[s]))
         begin
            v = endgame ? int'(PIECE_EG[b[s].kind]) : int'(PIECE_MG[b[s].kind]);
            sum = b[s].black ? sum - v : sum + v;
         end
      end
      return sum;
   endfunction

   function automatic int expected_eval(input board_t b);
      int     count;
      longint phase;
      longint blend;
      longint scaled;
      count = 0;
      for (int s = 0; s < 64; s++)
      begin
         if (is_piece(b[s]))
            count++;
      end
      phase = (count > MAX_PHASE) ? longint'(MAX_PHASE) : longint'(count);
      blend = table_sum(b, 1'b0) * phase + table_sum(b, 1'b1) * (MAX_PHASE - phase);
      scaled = blend * RECIP;
      return int'(scaled / SCALE);             // Integer divide truncates toward zero
   endfunction

   task automatic check_value(input string name, input longint actual, input longint expected);
      checks++;
      assert (actual == expected)
      else
      begin
         $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
         errors++;
      end
   endtask

   // Entered on the falling edge just after E0
   task automatic wait_eval_valid(output int cycles);
      cycles = 0;
      while (!eval_valid && cycles < TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!eval_valid)
      begin
         $display("Timeout: eval_valid did not rise within %0d cycles of a new board", TIMEOUT);
         $display("TEST FAILED");
         $finish;
      end
   endtask

   task automatic evaluate_board(input board_t b, output int exp_mat, output int exp_eval);
      int cycles;
      exp_mat = table_sum(b, 1'b0);
      exp_eval = expected_eval(b);
      @(negedge clk);
      board_in = b;
      board_valid = 1'b1;                      // Rise sampled at E0
      @(negedge clk);
      board_valid = 1'b0;
      board_in = random_board(1'b0);           // Board register must keep b
      wait_eval_valid(cycles);
      check_value("eval_valid latency", cycles, EXP_LATENCY);
      check_value("material", material, exp_mat);
      check_value("eval", eval, exp_eval);
   endtask

   // Result must not move while clear_eval stays low
   task automatic hold_result(input int exp_mat, input int exp_eval, input int n);
      repeat (n)
      begin
         @(negedge clk);
         check_value("eval_valid", eval_valid, 1);
         check_value("material", material, exp_mat);
         check_value("eval", eval, exp_eval);
      end
   endtask

   task automatic retire_result();
      @(negedge clk);
      clear_eval = 1'b1;
      @(negedge clk);
      clear_eval = 1'b0;
      check_value("eval_valid after clear", eval_valid, 0);
   endtask

   task automatic report_test(input string name);
      $display("%-14s %s", name, (errors == test_err) ? "passed" : "failed");
      test_err = errors;
   endtask

   initial
   begin
      board_t b;
      board_t next_b;
      int     exp_mat;
      int     exp_eval;
      clk = 1'b0;
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      clear_eval = 1'b0;
      checks = 0;
      errors = 0;
      test_err = 0;
      void'($urandom(32'h822c));              // Only seeding of the run
      repeat (8) @(negedge clk);
      reset = 1'b0;

      // Nothing announced without a board
      repeat (20)
      begin
         @(negedge clk);
         check_value("eval_valid", eval_valid, 0);
      end
      report_test("reset");

      for (int i = 0; i < NUM_BOARDS; i++)
      begin
         b = random_board(i % 10 == 9);        // Every tenth board dense
         evaluate_board(b, exp_mat, exp_eval);
         hold_result(exp_mat, exp_eval, int'($urandom_range(0, 30)));
         retire_result();
      end
      report_test("random boards");

      for (int i = 0; i < NUM_IGNORE; i++)
      begin
         b = random_board(1'b0);
         next_b = random_board(i % 2 == 1);
         evaluate_board(b, exp_mat, exp_eval);
         @(negedge clk);
         board_in = next_b;
         board_valid = 1'b1;                   // Rise outside IDLE
         hold_result(exp_mat, exp_eval, 5);
         retire_result();
         repeat (12)
         begin
            @(negedge clk);
            check_value("eval_valid on stale level", eval_valid, 0);
         end
         board_valid = 1'b0;                   // Fresh rise follows
         evaluate_board(next_b, exp_mat, exp_eval);
         hold_result(exp_mat, exp_eval, 3);
         retire_result();
      end
      report_test("ignored edges");

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* position_eval.f */
eval_pkg.sv
board_phase.sv
material_eval.sv
eval_sequencer.sv
taper_blend.sv
position_eval.sv
tb_position_eval.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the position evaluator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_position_eval -f position_eval.f -Mdir obj_dir
./obj_dir/Vtb_position_eval | tee sim.log

if grep -q "^TEST OK$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
